// ==== testbench/overlay_stimulus.txt ====
# command count : P n pair strobes, T n tick strobes, G game over
# F n scans one frame, n is the expected number of glyphs
F 28
P 9
F 28
P 1
F 28
T 150
F 28
T 5855
F 28
P 110
F 28
G
F 27
P 3
T 7
F 27

// ==== compile.f ====
rtl/text_pkg.sv
rtl/stats_pkg.sv
rtl/game_stats.sv
rtl/cell_scanner.sv
rtl/text_layout_rom.sv
rtl/cell_delay.sv
rtl/glyph_stream.sv
rtl/text_overlay_top.sv
testbench/tb_text_overlay.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the text overlay testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_text_overlay -f compile.f \
    --Mdir obj_dir -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation result: pass"
else
    echo "simulation result: fail, exit status $status"
    exit 1
fi

// ==== testbench/tb_text_overlay.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_text_overlay;

    localparam int    ACTIVE_COLS         = 17;
    localparam int    ACTIVE_ROWS         = 5;
    localparam int    TICKS_PER_HUNDREDTH = 1;
    localparam int    CLK_PERIOD          = 8;
    localparam string STIM_FILE           = "testbench/overlay_stimulus.txt";

    logic       clk;
    logic       rst_n;
    logic       tick;
    logic       pair_found;
    logic       game_over;
    logic       scan_strobe;
    logic       glyph_strobe;
    logic [9:0] glyph_yx;
    logic [6:0] glyph_code;
    logic       frame_done;
    logic [9:0] glyph_count;

    int         model_pairs;
    int         model_hund;                // stopwatch in hundredths 0..5999
    int         model_pre;
    bit         model_over;

    logic [9:0] exp_yx[$];                 // glyphs still owed by the DUT
    logic [6:0] exp_code[$];
    int         exp_count;
    bit         frame_pending = 1'b0;
    int         done_due      = 0;
    int         neg_cnt       = 0;
    int         cycle_budget  = 0;
    bit         budget_ready  = 1'b0;

    text_overlay_top #(
        .ACTIVE_COLS         (ACTIVE_COLS),
        .ACTIVE_ROWS         (ACTIVE_ROWS),
        .TICKS_PER_HUNDREDTH (TICKS_PER_HUNDREDTH)
    ) dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .tick         (tick),
        .pair_found   (pair_found),
        .game_over    (game_over),
        .scan_strobe  (scan_strobe),
        .glyph_strobe (glyph_strobe),
        .glyph_yx     (glyph_yx),
        .glyph_code   (glyph_code),
        .frame_done   (frame_done),
        .glyph_count  (glyph_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // error handling
    //////////////////////////////////////////////////

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t ns: %s", $time, what);
        abort_run();
    endtask

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // reference model of the statistics and layout
    //////////////////////////////////////////////////

    task automatic step_model(input bit pair_step);
        if (!model_over && pair_step) begin
            if (model_pairs < 99) begin
                model_pairs++;             // holds at 99
            end
        end else if (!model_over) begin
            model_pre++;
            if (model_pre == TICKS_PER_HUNDREDTH) begin
                model_pre  = 0;
                model_hund = (model_hund + 1) % 6000;  // 59.99 wraps to 00.00
            end
        end
    endtask

    function automatic string row_text(input int row);
        case (row)
            0:       return model_over ? "Game over!" : "Memory Game";
            2:       return $sformatf("Pairs: %02d", model_pairs);
            4:       return $sformatf("Time: %02d.%02d", model_hund / 100, model_hund % 100);
            default: return "";
        endcase
    endfunction

    // text starts at column 1 and spaces never reach the stream
    task automatic build_expected();
        string text;
        byte   ch;
        exp_yx.delete();
        exp_code.delete();
        exp_count = 0;
        for (int r = 0; r < ACTIVE_ROWS; r++) begin
            text = row_text(r);
            for (int c = 1; c < ACTIVE_COLS && c <= text.len(); c++) begin
                ch = text[c-1];
                if (ch != " ") begin
                    exp_yx.push_back({5'(r), 5'(c)});
                    exp_code.push_back(7'(ch));
                    exp_count++;
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // n strobes on back-to-back cycles
    task automatic drive_strobes(input bit pair_step, input int n);
        repeat (n) begin
            @(posedge clk);
            if (pair_step) begin
                pair_found <= 1'b1;
            end else begin
                tick <= 1'b1;
            end
            step_model(pair_step);
        end
        @(posedge clk);
        pair_found <= 1'b0;
        tick       <= 1'b0;
    endtask

    task automatic end_game();
        @(posedge clk);
        game_over <= 1'b1;
        @(posedge clk);
        game_over  <= 1'b0;
        model_over = 1'b1;
    endtask

    task automatic scan_frame(input int file_count);
        build_expected();
        check_equal("model glyph count", exp_count, file_count);
        repeat (ACTIVE_COLS * ACTIVE_ROWS) begin
            @(posedge clk);
            scan_strobe <= 1'b1;
        end
        done_due      = neg_cnt + 4;       // third cycle after the last request
        frame_pending = 1'b1;
        @(posedge clk);
        scan_strobe <= 1'b0;
        wait (!frame_pending);
    endtask

    // a dry pass only adds up the cycle budget
    task automatic run_commands(input bit execute);
        int    fd;
        int    arg;
        int    cost;
        string cmd;
        string rest;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            report_failure({"cannot open ", STIM_FILE});
        end
        while ($fscanf(fd, "%s", cmd) == 1) begin
            cost = 200;
            if (cmd.substr(0, 0) == "#") begin
                void'($fgets(rest, fd));
                cost = 0;
            end else if (cmd == "G") begin
                if (execute) begin
                    end_game();
                end
            end else if (cmd == "P" || cmd == "T" || cmd == "F") begin
                if ($fscanf(fd, "%d", arg) != 1) begin
                    report_failure({"no count after command ", cmd});
                end
                cost += (cmd == "F") ? ACTIVE_COLS * ACTIVE_ROWS : arg;
                if (execute && cmd == "F") begin
                    scan_frame(arg);
                end else if (execute) begin
                    drive_strobes(cmd == "P", arg);
                end
            end else begin
                report_failure({"unknown command ", cmd, " in the stimulus file"});
            end
            if (!execute) begin
                cycle_budget += cost;
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////
    // output monitor sampled at the falling edge
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        neg_cnt = neg_cnt + 1;
        if (glyph_strobe) begin
            if (exp_yx.size() == 0) begin
                report_failure("glyph_strobe while no glyph was expected");
            end else begin
                check_equal("glyph_yx", glyph_yx, exp_yx.pop_front());
                check_equal("glyph_code", glyph_code, exp_code.pop_front());
            end
        end
        if (frame_done) begin
            if (!frame_pending || neg_cnt != done_due) begin
                report_failure("frame_done not 3 cycles after the last scan_strobe");
            end else if (exp_yx.size() != 0) begin
                report_failure("frame ended before all expected glyphs arrived");
            end else begin
                check_equal("glyph_count", glyph_count, exp_count);
                frame_pending = 1'b0;
            end
        end else if (frame_pending && neg_cnt >= done_due) begin
            report_failure("frame_done missing 3 cycles after the last scan_strobe");
        end
    end

    initial begin
        wait (budget_ready);
        repeat (cycle_budget + 100) @(posedge clk);
        report_failure("watchdog expired, the run took longer than its commands allow");
    end

    initial begin
        rst_n       = 1'b0;
        tick        = 1'b0;
        pair_found  = 1'b0;
        game_over   = 1'b0;
        scan_strobe = 1'b0;
        model_pairs = 0;
        model_hund  = 0;
        model_pre   = 0;
        model_over  = 1'b0;
        run_commands(1'b0);
        budget_ready = 1'b1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        run_commands(1'b1);
        repeat (4) @(posedge clk);         // catch stray glyphs
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/text_overlay_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module text_overlay_top #(
    parameter int ACTIVE_COLS         = 17,
    parameter int ACTIVE_ROWS         = 5,
    parameter int TICKS_PER_HUNDREDTH = 1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 tick,
    input  logic                 pair_found,
    input  logic                 game_over,
    input  logic                 scan_strobe,
    output logic                 glyph_strobe,
    output text_pkg::cell_yx_t   glyph_yx,
    output text_pkg::char_code_t glyph_code,
    output logic                 frame_done,
    output logic [9:0]           glyph_count
);
    import text_pkg::*;
    import stats_pkg::*;

    pairs_bcd_t      pairs;
    seconds_bcd_t    seconds;
    hundredths_bcd_t hundredths;
    logic            over;

    logic            cell_strobe;
    logic            cell_last;
    cell_yx_t        cell_yx;
    char_code_t      char_code;

    logic [1:0]      aligned_ctl;        // {strobe, last}
    cell_yx_t        aligned_yx;

    game_stats #(
        .TICKS_PER_HUNDREDTH(TICKS_PER_HUNDREDTH)
    ) stats_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .pair_found (pair_found),
        .game_over  (game_over),
        .pairs      (pairs),
        .seconds    (seconds),
        .hundredths (hundredths),
        .over       (over)
    );

    cell_scanner #(
        .ACTIVE_COLS(ACTIVE_COLS),
        .ACTIVE_ROWS(ACTIVE_ROWS)
    ) scanner_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .scan_strobe (scan_strobe),
        .cell_strobe (cell_strobe),
        .cell_yx     (cell_yx),
        .cell_last   (cell_last)
    );

    text_layout_rom rom_i (
        .clk        (clk),
        .cell_yx    (cell_yx),
        .over       (over),
        .pairs      (pairs),
        .seconds    (seconds),
        .hundredths (hundredths),
        .char_code  (char_code)
    );

    // match the rom latency
    cell_delay #(
        .payload_t(logic [1:0])
    ) ctl_delay_i (
        .clk   (clk),
        .rst_n (rst_n),
        .d     ({cell_strobe, cell_last}),
        .q     (aligned_ctl)
    );

    cell_delay #(
        .payload_t(cell_yx_t)
    ) yx_delay_i (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (cell_yx),
        .q     (aligned_yx)
    );

    glyph_stream stream_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cell_strobe  (aligned_ctl[1]),
        .cell_last    (aligned_ctl[0]),
        .cell_yx      (aligned_yx),
        .char_code    (char_code),
        .glyph_strobe (glyph_strobe),
        .glyph_yx     (glyph_yx),
        .glyph_code   (glyph_code),
        .frame_done   (frame_done),
        .glyph_count  (glyph_count)
    );

endmodule

`default_nettype wire

// ==== rtl/glyph_stream.sv ====
`timescale 1ns/1ns
`default_nettype none

module glyph_stream (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cell_strobe,
    input  logic                 cell_last,
    input  text_pkg::cell_yx_t   cell_yx,
    input  text_pkg::char_code_t char_code,
    output logic                 glyph_strobe,
    output text_pkg::cell_yx_t   glyph_yx,
    output text_pkg::char_code_t glyph_code,
    output logic                 frame_done,
    output logic [9:0]           glyph_count
);
    import text_pkg::*;

    logic       visible;
    logic       frame_end;
    logic [9:0] run_count;

    assign visible   = cell_strobe && (char_code != CHAR_BLANK);
    assign frame_end = cell_strobe && cell_last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            glyph_strobe <= 1'b0;
            frame_done   <= 1'b0;
            glyph_count  <= '0;
            run_count    <= '0;
        end else begin
            glyph_strobe <= visible;
            frame_done   <= frame_end;
            if (frame_end) begin
                glyph_count <= run_count + 10'(visible);  // last cell counts too
                run_count   <= '0;
            end else if (visible) begin
                run_count <= run_count + 1'b1;
            end
        end
    end

    // glyph payload
    always_ff @(posedge clk) begin
        if (visible) begin
            glyph_yx   <= cell_yx;
            glyph_code <= char_code;
        end
    end

    a_no_blank: assert property (@(posedge clk) disable iff (!rst_n)
        glyph_strobe |-> glyph_code != CHAR_BLANK);

endmodule

`default_nettype wire

// ==== rtl/cell_delay.sv ====
`timescale 1ns/1ns
`default_nettype none

// one register stage, shared by every scanner signal that has to
// wait for the layout rom
module cell_delay #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else begin
            q <= d;                        // one cycle, no enable
        end
    end

endmodule

`default_nettype wire

// ==== rtl/text_layout_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

module text_layout_rom (
    input  logic                       clk,
    input  text_pkg::cell_yx_t         cell_yx,
    input  logic                       over,
    input  stats_pkg::pairs_bcd_t      pairs,
    input  stats_pkg::seconds_bcd_t    seconds,
    input  stats_pkg::hundredths_bcd_t hundredths,
    output text_pkg::char_code_t       char_code
);
    import text_pkg::*;

    char_code_t data;

    always_ff @(posedge clk) begin
        char_code <= data;
    end

    // spaces inside a line are blank cells
    always_comb begin
        case (cell_yx)
            //////////////////////////////////////////////////
            // row 0, title or end banner
            //////////////////////////////////////////////////
            10'h001: data = over ? 7'("G") : 7'("M");
            10'h002: data = over ? 7'("a") : 7'("e");
            10'h003: data = 7'("m");
            10'h004: data = over ? 7'("e") : 7'("o");
            10'h005: data = over ? CHAR_BLANK : 7'("r");
            10'h006: data = over ? 7'("o") : 7'("y");
            10'h007: data = over ? 7'("v") : CHAR_BLANK;
            10'h008: data = over ? 7'("e") : 7'("G");
            10'h009: data = over ? 7'("r") : 7'("a");
            10'h00a: data = over ? 7'("!") : 7'("m");
            10'h00b: data = over ? CHAR_BLANK : 7'("e");

            //////////////////////////////////////////////////
            // row 2, pairs found
            //////////////////////////////////////////////////
            10'h041: data = 7'("P");
            10'h042: data = 7'("a");
            10'h043: data = 7'("i");
            10'h044: data = 7'("r");
            10'h045: data = 7'("s");
            10'h046: data = 7'(":");
            10'h048: data = digit_char(pairs.tens);
            10'h049: data = digit_char(pairs.units);

            //////////////////////////////////////////////////
            // row 4, stopwatch
            //////////////////////////////////////////////////
            10'h081: data = 7'("T");
            10'h082: data = 7'("i");
            10'h083: data = 7'("m");
            10'h084: data = 7'("e");
            10'h085: data = 7'(":");
            10'h087: data = digit_char({1'b0, seconds.tens});
            10'h088: data = digit_char(seconds.units);
            10'h089: data = 7'(".");
            10'h08a: data = digit_char(hundredths.tens);
            10'h08b: data = digit_char(hundredths.units);

            default: data = CHAR_BLANK;      // rest of the grid is empty
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/cell_scanner.sv ====
`timescale 1ns/1ns
`default_nettype none

module cell_scanner #(
    parameter int ACTIVE_COLS = 17,
    parameter int ACTIVE_ROWS = 5
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               scan_strobe,
    output logic               cell_strobe,
    output text_pkg::cell_yx_t cell_yx,
    output logic               cell_last
);
    import text_pkg::*;

    localparam logic [GRID_BITS-1:0] LAST_COL = GRID_BITS'(ACTIVE_COLS - 1);
    localparam logic [GRID_BITS-1:0] LAST_ROW = GRID_BITS'(ACTIVE_ROWS - 1);

    logic [GRID_BITS-1:0] col;
    logic [GRID_BITS-1:0] row;
    logic                 col_end;
    logic                 row_end;

    assign col_end = (col == LAST_COL);
    assign row_end = (row == LAST_ROW);

    // position counters, advanced once per request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col         <= '0;
            row         <= '0;
            cell_strobe <= 1'b0;
        end else begin
            cell_strobe <= scan_strobe;
            if (scan_strobe) begin
                col <= col_end ? '0 : col + 1'b1;
                if (col_end) begin
                    row <= row_end ? '0 : row + 1'b1;  // wrap to top of frame
                end
            end
        end
    end

    // cell payload, qualified by cell_strobe
    always_ff @(posedge clk) begin
        if (scan_strobe) begin
            cell_yx   <= {row, col};
            cell_last <= col_end && row_end;
        end
    end

    a_col_range: assert property (@(posedge clk) disable iff (!rst_n)
        int'(col) < ACTIVE_COLS);

endmodule

`default_nettype wire

// ==== rtl/game_stats.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_stats #(
    parameter int TICKS_PER_HUNDREDTH = 1
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       tick,
    input  logic                       pair_found,
    input  logic                       game_over,
    output stats_pkg::pairs_bcd_t      pairs,
    output stats_pkg::seconds_bcd_t    seconds,
    output stats_pkg::hundredths_bcd_t hundredths,
    output logic                       over
);
    import stats_pkg::*;

    localparam int PRE_W = (TICKS_PER_HUNDREDTH > 1) ? $clog2(TICKS_PER_HUNDREDTH) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TICKS_PER_HUNDREDTH - 1);

    logic [PRE_W-1:0] pre_cnt;
    logic             tick_en;
    logic             hund_step;
    logic             hund_units_wrap;
    logic             hund_wrap;
    logic             sec_units_wrap;
    logic             sec_wrap;
    logic             pairs_full;

    assign tick_en         = tick && !over;
    assign hund_step       = tick_en && (pre_cnt == PRE_LAST);
    assign hund_units_wrap = (hundredths.units == BCD_MAX);
    assign hund_wrap       = hund_units_wrap && (hundredths.tens == BCD_MAX);
    assign sec_units_wrap  = (seconds.units == BCD_MAX);
    assign sec_wrap        = sec_units_wrap && (seconds.tens == SEC_TENS_MAX); // 59.99
    assign pairs_full      = (pairs.tens == BCD_MAX) && (pairs.units == BCD_MAX);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            over <= 1'b0;
        end else if (game_over) begin
            over <= 1'b1;                  // sticky until reset
        end
    end

    // tick prescaler
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_cnt <= '0;
        end else if (tick_en) begin
            pre_cnt <= (pre_cnt == PRE_LAST) ? '0 : pre_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // pairs counter saturating at 99
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pairs <= '0;
        end else if (pair_found && !over && !pairs_full) begin
            if (pairs.units == BCD_MAX) begin
                pairs.units <= '0;
                pairs.tens  <= pairs.tens + 1'b1;
            end else begin
                pairs.units <= pairs.units + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // stopwatch ss.hh
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hundredths <= '0;
            seconds    <= '0;
        end else if (hund_step) begin
            hundredths.units <= hund_units_wrap ? '0 : hundredths.units + 1'b1;
            if (hund_units_wrap) begin
                hundredths.tens <= hund_wrap ? '0 : hundredths.tens + 1'b1;
            end
            if (hund_wrap) begin            // carry into seconds
                seconds.units <= sec_units_wrap ? '0 : seconds.units + 1'b1;
                if (sec_units_wrap) begin
                    seconds.tens <= sec_wrap ? '0 : seconds.tens + 1'b1;
                end
            end
        end
    end

    a_bcd_range: assert property (@(posedge clk) disable iff (!rst_n)
        pairs.tens <= BCD_MAX && pairs.units <= BCD_MAX &&
        hundredths.tens <= BCD_MAX && hundredths.units <= BCD_MAX &&
        seconds.tens <= SEC_TENS_MAX && seconds.units <= BCD_MAX);

endmodule

`default_nettype wire

// ==== rtl/stats_pkg.sv ====
`default_nettype none

package stats_pkg;

    typedef logic [3:0] bcd_digit_t;

    typedef struct packed {
        bcd_digit_t tens;
        bcd_digit_t units;
    } pairs_bcd_t;                         // 00..99

    typedef struct packed {
        logic [2:0] tens;                  // 0..5
        bcd_digit_t units;
    } seconds_bcd_t;

    typedef struct packed {
        bcd_digit_t tens;
        bcd_digit_t units;
    } hundredths_bcd_t;

    localparam bcd_digit_t BCD_MAX      = 4'd9;
    localparam logic [2:0] SEC_TENS_MAX = 3'd5;

endpackage

`default_nettype wire

// ==== rtl/text_pkg.sv ====
`default_nettype none

package text_pkg;

    //////////////////////////////////////////////////
    // character grid
    //////////////////////////////////////////////////

    localparam int GRID_BITS = 5;          // 32 cells per coordinate

    // {row, column}, row in the upper half
    typedef logic [2*GRID_BITS-1:0] cell_yx_t;

    //////////////////////////////////////////////////
    // character codes
    //////////////////////////////////////////////////

    typedef logic [6:0] char_code_t;       // 7-bit ascii

    // the font has no glyph at code 0, so a space is written as blank
    localparam char_code_t CHAR_BLANK = 7'd0;
    localparam char_code_t CHAR_ZERO  = 7'h30;

    // ascii digit for one bcd value
    function automatic char_code_t digit_char(input logic [3:0] value);
        return CHAR_ZERO + char_code_t'(value);
    endfunction

endpackage

`default_nettype wire
